// ==== list.f ====
+incdir+src
src/isaPkg.sv
src/pipePkg.sv
src/registerFile.sv
src/fetchDecode.sv
src/executeStage.sv
src/memoryStage.sv
src/mips32Top.sv
verification/mips32Tb.sv

// ==== Bender.yml ====
package:
  name: mips32

sources:
  - include_dirs:
      - src
    files:
      - src/isaPkg.sv
      - src/pipePkg.sv
      - src/registerFile.sv
      - src/fetchDecode.sv
      - src/executeStage.sv
      - src/memoryStage.sv
      - src/mips32Top.sv
  - target: test
    include_dirs:
      - src
    files:
      - verification/mips32Tb.sv

// ==== verification/mips32Tb.sv ====
// ########################################
// random stream from a fixed LFSR seed, model runs at each handshake
// inputs change on the falling edge, outputs sampled at the rising edge
// ########################################
`timescale 1ns/10ps
`include "mips32_params.svh"

module mips32Tb
	import isaPkg::*;
();

	localparam int NUM_INST = 2000;
	localparam int WATCHDOG_CYCLES = NUM_INST * 4 + 100;
	localparam logic [31:0] LFSR_TAPS = 32'h80200003;
	localparam logic [5:0] OP_UNDEF = 6'h3f;
	localparam logic [1:0] READY_HIGH = 2'd0;
	localparam logic [1:0] READY_LOW = 2'd1;
	localparam logic [1:0] READY_ANY = 2'd2; // undefined opcode waiting in ID

	logic clk;
	logic rst;
	logic [31:0] inst;
	logic instValid;
	logic instReady;
	logic regWrite;
	logic [4:0] regAddr;
	logic [31:0] regData;
	logic memWr;
	logic [`DATA_MEM_ADDR_SIZE-1:0] memAddr;
	logic [31:0] memData;

	logic [31:0] lfsr = 32'h44e;
	logic [31:0] modelRegs [`REG_COUNT];
	logic [31:0] modelMem [`DATA_MEM_WORDS];
	logic [4:0] expRegAddr [$];
	logic [31:0] expRegData [$];
	logic [`DATA_MEM_ADDR_SIZE-1:0] expMemAddr [$];
	logic [31:0] expMemData [$];
	int acceptCount = 0;
	int edgeCount = 0;
	int regErrors = 0;
	int memErrors = 0;
	int readyErrors = 0;
	int otherErrors = 0;
	logic wasRst = 1'b1;
	logic [1:0] readyExp = READY_HIGH;
	// what sits in ID and EX, for the load-use prediction
	logic idFull = 1'b0;
	logic [31:0] idInst;
	logic exLoadM = 1'b0;
	logic [4:0] exDestM;

	mips32Top dut0 (
		.clk, .rst, .inst, .instValid, .instReady,
		.regWrite, .regAddr, .regData,
		.memWr, .memAddr, .memData
	);

	initial clk = 1'b0;
	always #4 clk = ~clk;

	function automatic logic nextBit();
		logic out;
		out = lfsr[0];
		lfsr = (lfsr >> 1) ^ (out ? LFSR_TAPS : 32'd0);
		return out;
	endfunction

	function automatic logic [31:0] takeBits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
			v = {v[30:0], nextBit()};
		return v;
	endfunction

	// registers r0..r7 only, so dependences are frequent
	function automatic logic [31:0] makeInst();
		logic [3:0] kind;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [15:0] imm;
		kind = 4'(takeBits(4));
		rs = 5'(takeBits(3));
		rt = 5'(takeBits(3));
		rd = 5'(takeBits(3));
		imm = 16'(takeBits(16));
		case (kind)
			4'd0, 4'd1: return {OP_RTYPE, rs, rt, rd, 5'd0, FN_ADD};
			4'd2: return {OP_RTYPE, rs, rt, rd, 5'd0, FN_SUB};
			4'd3: return {OP_RTYPE, rs, rt, rd, 5'd0, FN_AND};
			4'd4: return {OP_RTYPE, rs, rt, rd, 5'd0, FN_OR};
			4'd5, 4'd6: return {OP_RTYPE, rs, rt, rd, 5'd0, FN_SLT};
			4'd7, 4'd8: return {OP_ADDI, rs, rt, imm};
			4'd9: return {OP_ANDI, rs, rt, imm};
			4'd10: return {OP_ORI, rs, rt, imm};
			4'd11, 4'd12: return {OP_LW, rs, rt, imm};
			4'd13, 4'd14: return {OP_SW, rs, rt, imm};
			default: return {OP_UNDEF, rs, rt, imm};
		endcase
	endfunction

	task automatic expectWrite(input logic [4:0] dest, input logic [31:0] value);
		if (dest != 5'd0) begin
			modelRegs[dest] = value;
			expRegAddr.push_back(dest);
			expRegData.push_back(value);
		end
	endtask

	task automatic runModel(input logic [31:0] w);
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] sImm;
		logic [31:0] byteAddr;
		logic [`DATA_MEM_ADDR_SIZE-1:0] wordAddr;
		a = modelRegs[w[25:21]];
		b = modelRegs[w[20:16]];
		sImm = {{16{w[15]}}, w[15:0]};
		byteAddr = a + sImm;
		wordAddr = byteAddr[`DATA_MEM_ADDR_SIZE+1:2];
		case (w[31:26])
			OP_RTYPE: begin
				case (w[5:0])
					FN_ADD: expectWrite(w[15:11], a + b);
					FN_SUB: expectWrite(w[15:11], a - b);
					FN_AND: expectWrite(w[15:11], a & b);
					FN_OR: expectWrite(w[15:11], a | b);
					FN_SLT: expectWrite(w[15:11], ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
					default: ;
				endcase
			end
			OP_ADDI: expectWrite(w[20:16], byteAddr);
			OP_ANDI: expectWrite(w[20:16], a & {16'd0, w[15:0]});
			OP_ORI: expectWrite(w[20:16], a | {16'd0, w[15:0]});
			OP_LW: expectWrite(w[20:16], modelMem[wordAddr]);
			OP_SW: begin
				modelMem[wordAddr] = b;
				expMemAddr.push_back(wordAddr);
				expMemData.push_back(b);
			end
			default: ; // retires with no effect
		endcase
	endtask

	// ID waits one cycle when it reads what the load in EX writes
	function automatic logic [1:0] hazardAhead();
		logic [5:0] op;
		logic match;
		op = idInst[31:26];
		match = idInst[25:21] == exDestM ||
			((op == OP_RTYPE || op == OP_SW) && idInst[20:16] == exDestM);
		if (!idFull || !exLoadM || !match)
			return READY_HIGH;
		if (op == OP_UNDEF)
			return READY_ANY;
		return READY_LOW;
	endfunction

	task automatic trackPipe(input logic stalled, input logic took);
		if (stalled) begin
			exLoadM = 1'b0; // bubble enters EX
		end else begin
			exLoadM = idFull && idInst[31:26] == OP_LW && idInst[20:16] != 5'd0;
			exDestM = idInst[20:16];
			idFull = took;
			if (took)
				idInst = inst;
		end
		readyExp = hazardAhead();
	endtask

	task automatic checkReady();
		if (readyExp != READY_ANY) begin
			assert (instReady == (readyExp == READY_HIGH)) else begin
				readyErrors++;
				$display("CHECK FAILED instReady got %h expected %h at edge %0d",
					instReady, readyExp == READY_HIGH, edgeCount);
			end
		end
	endtask

	task automatic checkRegWrite();
		logic [4:0] expA;
		logic [31:0] expD;
		if (regWrite) begin
			assert (regAddr != 5'd0) else begin
				regErrors++;
				$display("CHECK FAILED regAddr got %h on a write", regAddr);
			end
			assert (expRegAddr.size() > 0) else begin
				regErrors++;
				$display("register write to r%0d arrived with none expected", regAddr);
			end
			if (expRegAddr.size() > 0) begin
				expA = expRegAddr.pop_front();
				expD = expRegData.pop_front();
				assert (regAddr == expA) else begin
					regErrors++;
					$display("CHECK FAILED regAddr got %h expected %h", regAddr, expA);
				end
				assert (regData == expD) else begin
					regErrors++;
					$display("CHECK FAILED regData got %h expected %h", regData, expD);
				end
			end
		end
	endtask

	task automatic checkStore();
		logic [`DATA_MEM_ADDR_SIZE-1:0] expA;
		logic [31:0] expD;
		if (memWr) begin
			assert (expMemAddr.size() > 0) else begin
				memErrors++;
				$display("store to word %0d arrived with none expected", memAddr);
			end
			if (expMemAddr.size() > 0) begin
				expA = expMemAddr.pop_front();
				expD = expMemData.pop_front();
				assert (memAddr == expA) else begin
					memErrors++;
					$display("CHECK FAILED memAddr got %h expected %h", memAddr, expA);
				end
				assert (memData == expD) else begin
					memErrors++;
					$display("CHECK FAILED memData got %h expected %h", memData, expD);
				end
			end
		end
	endtask

	task automatic finishRun();
		assert (expRegAddr.size() == 0 && expMemAddr.size() == 0) else begin
			otherErrors++;
			$display("%0d register writes and %0d stores never appeared",
				expRegAddr.size(), expMemAddr.size());
		end
		$display("errors: register %0d, store %0d, ready %0d, other %0d",
			regErrors, memErrors, readyErrors, otherErrors);
		if (regErrors + memErrors + readyErrors + otherErrors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	endtask

	always @(posedge clk) begin
		edgeCount++;
		if (rst || wasRst) begin
			// first edge skipped, flops still unknown
			if (edgeCount > 1) begin
				assert (instReady === 1'b0 && regWrite === 1'b0 && memWr === 1'b0) else begin
					otherErrors++;
					$display("CHECK FAILED instReady/regWrite/memWr got %h/%h/%h expected 0",
						instReady, regWrite, memWr);
				end
			end
		end else begin
			checkReady();
			checkRegWrite();
			checkStore();
			if (instValid && instReady) begin
				acceptCount++;
				runModel(inst);
			end
			trackPipe(!instReady, instValid && instReady);
		end
		wasRst = rst;
	end

	initial begin
		int issued;
		issued = 0;
		rst = 1'b1;
		inst = '0;
		instValid = 1'b0;
		for (int i = 0; i < `REG_COUNT; i++)
			modelRegs[i] = '0;
		for (int i = 0; i < `DATA_MEM_WORDS; i++)
			modelMem[i] = '0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		while (acceptCount < NUM_INST) begin
			if (acceptCount == issued) begin // previous one taken
				inst = makeInst();
				issued++;
			end
			instValid = takeBits(4) < 13; // roughly 80 % valid
			@(negedge clk);
		end
		instValid = 1'b0;
		while (expRegAddr.size() > 0 || expMemAddr.size() > 0)
			@(negedge clk);
		repeat (6) @(negedge clk); // room for stray late pulses
		finishRun();
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		otherErrors++;
		$display("watchdog expired after %0d cycles with %0d of %0d instructions accepted",
			WATCHDOG_CYCLES, acceptCount, NUM_INST);
		finishRun();
	end

endmodule

// ==== src/mips32Top.sv ====
// ######################################
// instruction stream in, no output back-pressure
// ######################################
`timescale 1ns/10ps
`include "mips32_params.svh"

module mips32Top
	import pipePkg::*;
(
	input logic clk,
	input logic rst,
	input logic [31:0] inst,
	input logic instValid,
	output logic instReady,
	output logic regWrite,
	output logic [4:0] regAddr,
	output logic [31:0] regData,
	output logic memWr,
	output logic [`DATA_MEM_ADDR_SIZE-1:0] memAddr,
	output logic [31:0] memData
);

	// ID to EX
	logic idValid, idRegWe, idMemRe, idMemWe, idUseImm;
	aluOp_t idAluOp;
	wbSrc_t idWbSrc;
	logic [4:0] idRs, idRt, idDest;
	logic [31:0] idRsValue, idRtValue, idImm;
	logic [4:0] rfRsAddr, rfRtAddr;
	logic [31:0] rfRsData, rfRtData;
	// EX to MEM, hazard back to ID
	logic exLoad, exValid, exRegWe, exMemRe, exMemWe;
	logic [4:0] exDest, exDestOut;
	wbSrc_t exWbSrc;
	logic [31:0] exAluResult, exStoreData;
	// MEM forwarding
	logic [4:0] memDest;
	logic memRegWe;
	logic [31:0] memAluResult;

	fetchDecode fetchDecode (
		.clk, .rst, .inst, .instValid, .instReady,
		.exLoad, .exDest,
		.rfRsAddr, .rfRtAddr, .rfRsData, .rfRtData,
		.idValid, .idRegWe, .idMemRe, .idMemWe, .idUseImm,
		.idAluOp, .idWbSrc, .idRs, .idRt, .idDest,
		.idRsValue, .idRtValue, .idImm
	);

	registerFile registerFile (
		.clk, .rst,
		.rsAddr (rfRsAddr),
		.rtAddr (rfRtAddr),
		.wrAddr (regAddr),
		.wrEn (regWrite),
		.wrData (regData),
		.rsData (rfRsData),
		.rtData (rfRtData)
	);

	executeStage executeStage (
		.clk, .rst,
		.idValid, .idRegWe, .idMemRe, .idMemWe, .idUseImm,
		.idAluOp, .idWbSrc, .idRs, .idRt, .idDest,
		.idRsValue, .idRtValue, .idImm,
		.memDest, .memRegWe, .memAluResult,
		.wbDest (regAddr), .wbRegWe (regWrite), .wbData (regData), // WB forward
		.exLoad, .exDest, .exValid, .exRegWe, .exMemRe, .exMemWe,
		.exWbSrc, .exAluResult, .exStoreData, .exDestOut
	);

	memoryStage memoryStage (
		.clk, .rst,
		.exValid, .exRegWe, .exMemRe, .exMemWe, .exWbSrc,
		.exAluResult, .exStoreData,
		.exDest (exDestOut),
		.memDest, .memRegWe, .memAluResult,
		.memWr, .memAddr, .memData,
		.regWrite, .regAddr, .regData
	);

endmodule

// ==== src/memoryStage.sv ====
// ######################################
// 64-word data memory, cleared by reset
// address bits 1:0 are ignored
// ######################################
`timescale 1ns/10ps
`include "mips32_params.svh"

module memoryStage
	import pipePkg::*;
(
	input logic clk,
	input logic rst,
	input logic exValid,
	input logic exRegWe,
	input logic exMemRe,
	input logic exMemWe,
	input wbSrc_t exWbSrc,
	input logic [31:0] exAluResult,
	input logic [31:0] exStoreData,
	input logic [4:0] exDest,
	output logic [4:0] memDest,
	output logic memRegWe,
	output logic [31:0] memAluResult,
	output logic memWr,
	output logic [`DATA_MEM_ADDR_SIZE-1:0] memAddr,
	output logic [31:0] memData,
	output logic regWrite,
	output logic [4:0] regAddr,
	output logic [31:0] regData
);

	logic validQ, regWeQ, memReQ, memWeQ;
	wbSrc_t wbSrcQ, wbSelQ;
	logic [31:0] dataMem [`DATA_MEM_WORDS];
	logic [31:0] loadData;
	logic [31:0] wbLoadQ, wbAluQ;

	// EX/MEM
	always_ff @(posedge clk) begin
		if (rst) begin
			validQ <= 1'b0;
			regWeQ <= 1'b0;
			memReQ <= 1'b0;
			memWeQ <= 1'b0;
		end else begin
			validQ <= exValid;
			regWeQ <= exRegWe;
			memReQ <= exMemRe;
			memWeQ <= exMemWe;
		end
	end

	always_ff @(posedge clk) begin
		wbSrcQ <= exWbSrc;
		memAluResult <= exAluResult;
		memData <= exStoreData;
		memDest <= exDest;
	end

	assign memRegWe = validQ && regWeQ;
	assign memWr = validQ && memWeQ;
	assign memAddr = memAluResult[`DATA_MEM_ADDR_SIZE+1:2]; // word address

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `DATA_MEM_WORDS; i++)
				dataMem[i] <= '0;
		end else if (memWr) begin
			dataMem[memAddr] <= memData;
		end
	end

	assign loadData = dataMem[memAddr];

	// MEM/WB
	always_ff @(posedge clk) begin
		if (rst)
			regWrite <= 1'b0;
		else
			regWrite <= memRegWe;
	end

	always_ff @(posedge clk) begin
		wbSelQ <= wbSrcQ;
		regAddr <= memDest;
		wbLoadQ <= loadData;
		wbAluQ <= memAluResult;
	end

	assign regData = (wbSelQ == WB_MEM) ? wbLoadQ : wbAluQ;

	// a store is not a load and retires without a register write
	aStoreOnly: assert property (@(posedge clk) disable iff (rst)
		memWr |-> !memReQ ##1 !regWrite);

endmodule

// ==== src/executeStage.sv ====
// ######################################
// forwarding from MEM then WB, no branches
// loads in MEM are covered by the ID stall
// ######################################
`timescale 1ns/10ps

module executeStage
	import pipePkg::*;
(
	input logic clk,
	input logic rst,
	input logic idValid,
	input logic idRegWe,
	input logic idMemRe,
	input logic idMemWe,
	input logic idUseImm,
	input aluOp_t idAluOp,
	input wbSrc_t idWbSrc,
	input logic [4:0] idRs,
	input logic [4:0] idRt,
	input logic [4:0] idDest,
	input logic [31:0] idRsValue,
	input logic [31:0] idRtValue,
	input logic [31:0] idImm,
	input logic [4:0] memDest,
	input logic memRegWe,
	input logic [31:0] memAluResult,
	input logic [4:0] wbDest,
	input logic wbRegWe,
	input logic [31:0] wbData,
	output logic exLoad,
	output logic [4:0] exDest,
	output logic exValid,
	output logic exRegWe,
	output logic exMemRe,
	output logic exMemWe,
	output wbSrc_t exWbSrc,
	output logic [31:0] exAluResult,
	output logic [31:0] exStoreData,
	output logic [4:0] exDestOut
);

	logic useImmQ;
	aluOp_t aluOpQ;
	logic [4:0] rsQ, rtQ, destQ;
	logic [31:0] rsValueQ, rtValueQ, immQ;
	logic fwdRsMem, fwdRtMem;
	logic rtUsed;
	logic memIsLoad; // previous EX instruction was a load
	logic [31:0] opA, opB;

	always_ff @(posedge clk) begin
		if (rst) begin
			exValid <= 1'b0;
			exRegWe <= 1'b0;
			exMemRe <= 1'b0;
			exMemWe <= 1'b0;
			memIsLoad <= 1'b0;
		end else begin
			exValid <= idValid;
			exRegWe <= idValid && idRegWe;
			exMemRe <= idValid && idMemRe;
			exMemWe <= idValid && idMemWe;
			memIsLoad <= exLoad;
		end
	end

	always_ff @(posedge clk) begin
		useImmQ <= idUseImm;
		aluOpQ <= idAluOp;
		exWbSrc <= idWbSrc;
		rsQ <= idRs;
		rtQ <= idRt;
		destQ <= idDest;
		rsValueQ <= idRsValue;
		rtValueQ <= idRtValue;
		immQ <= idImm;
	end

	assign fwdRsMem = memRegWe && memDest == rsQ;
	assign fwdRtMem = memRegWe && memDest == rtQ;
	assign rtUsed = !useImmQ || exMemWe;

	assign opA = fwdRsMem ? memAluResult :
		(wbRegWe && wbDest == rsQ) ? wbData : rsValueQ;
	assign exStoreData = fwdRtMem ? memAluResult :
		(wbRegWe && wbDest == rtQ) ? wbData : rtValueQ;
	assign opB = useImmQ ? immQ : exStoreData;

	always_comb begin
		case (aluOpQ)
			ALU_SUB: exAluResult = opA - opB;
			ALU_AND: exAluResult = opA & opB;
			ALU_OR: exAluResult = opA | opB;
			ALU_SLT: exAluResult = {31'd0, $signed(opA) < $signed(opB)};
			default: exAluResult = opA + opB; // add, also address calc
		endcase
	end

	assign exLoad = exValid && exMemRe && exRegWe;
	assign exDest = destQ;
	assign exDestOut = destQ;

	// aluResult of a load in MEM is an address, never forward it
	aNoLoadFwd: assert property (@(posedge clk) disable iff (rst)
		exValid && memIsLoad |-> !(fwdRsMem || (rtUsed && fwdRtMem)));

endmodule

// ==== src/fetchDecode.sv ====
// ######################################
// takes the instruction stream directly without a PC
// undefined opcodes decode to a no-op
// ######################################
`timescale 1ns/10ps

module fetchDecode
	import isaPkg::*;
	import pipePkg::*;
(
	input logic clk,
	input logic rst,
	input instWord_t inst,
	input logic instValid,
	output logic instReady,
	input logic exLoad,
	input logic [4:0] exDest,
	output logic [4:0] rfRsAddr,
	output logic [4:0] rfRtAddr,
	input logic [31:0] rfRsData,
	input logic [31:0] rfRtData,
	output logic idValid,
	output logic idRegWe,
	output logic idMemRe,
	output logic idMemWe,
	output logic idUseImm,
	output aluOp_t idAluOp,
	output wbSrc_t idWbSrc,
	output logic [4:0] idRs,
	output logic [4:0] idRt,
	output logic [4:0] idDest,
	output logic [31:0] idRsValue,
	output logic [31:0] idRtValue,
	output logic [31:0] idImm
);

	instWord_t ifIdInst;
	logic ifIdValid;
	logic runReg; // low through reset and one cycle after
	logic accept;
	logic loadUseStall;
	logic usesRt;
	logic decRegWe;
	logic signExt;

	assign accept = instValid && instReady;
	assign instReady = runReg && !loadUseStall;

	always_ff @(posedge clk) begin
		if (rst) begin
			runReg <= 1'b0;
			ifIdValid <= 1'b0;
		end else begin
			runReg <= 1'b1;
			if (!loadUseStall)
				ifIdValid <= accept; // hold on stall
		end
	end

	always_ff @(posedge clk) begin
		if (accept)
			ifIdInst <= inst;
	end

	always_comb begin
		decRegWe = 1'b0;
		idMemRe = 1'b0;
		idMemWe = 1'b0;
		idUseImm = 1'b1;
		idAluOp = ALU_ADD;
		idWbSrc = WB_ALU;
		idDest = ifIdInst.iFormat.rt;
		usesRt = 1'b0;
		signExt = 1'b1;
		case (ifIdInst.rFormat.opcode)
			OP_RTYPE: begin
				idUseImm = 1'b0;
				idDest = ifIdInst.rFormat.rd;
				usesRt = 1'b1;
				decRegWe = 1'b1;
				case (ifIdInst.rFormat.funct)
					FN_ADD: idAluOp = ALU_ADD;
					FN_SUB: idAluOp = ALU_SUB;
					FN_AND: idAluOp = ALU_AND;
					FN_OR: idAluOp = ALU_OR;
					FN_SLT: idAluOp = ALU_SLT;
					default: decRegWe = 1'b0; // unknown funct
				endcase
			end
			OP_ADDI: decRegWe = 1'b1;
			OP_ANDI: begin
				decRegWe = 1'b1;
				idAluOp = ALU_AND;
				signExt = 1'b0;
			end
			OP_ORI: begin
				decRegWe = 1'b1;
				idAluOp = ALU_OR;
				signExt = 1'b0;
			end
			OP_LW: begin
				decRegWe = 1'b1;
				idMemRe = 1'b1;
				idWbSrc = WB_MEM;
			end
			OP_SW: begin
				idMemWe = 1'b1;
				usesRt = 1'b1; // store data
			end
			default: ;
		endcase
	end

	assign idRegWe = decRegWe && (idDest != 5'd0);
	assign idImm = signExt ? {{16{ifIdInst.iFormat.imm16[15]}}, ifIdInst.iFormat.imm16}
		: {16'd0, ifIdInst.iFormat.imm16};

	assign rfRsAddr = ifIdInst.rFormat.rs;
	assign rfRtAddr = ifIdInst.rFormat.rt;
	assign idRs = ifIdInst.rFormat.rs;
	assign idRt = ifIdInst.rFormat.rt;
	assign idRsValue = rfRsData;
	assign idRtValue = rfRtData;

	// exLoad already implies a nonzero exDest
	assign loadUseStall = ifIdValid && exLoad &&
		(idRs == exDest || (usesRt && idRt == exDest));
	assign idValid = ifIdValid && !loadUseStall; // bubble into EX

	// a load-use stall lasts one cycle
	aReadyLow: assert property (@(posedge clk) disable iff (rst)
		runReg && !instReady |=> instReady);

endmodule

// ==== src/registerFile.sv ====
// ######################################
// 32x32 regs, r0 hardwired to zero
// reads see a same-cycle write
// ######################################
`timescale 1ns/10ps
`include "mips32_params.svh"

module registerFile (
	input logic clk,
	input logic rst,
	input logic [4:0] rsAddr,
	input logic [4:0] rtAddr,
	input logic [4:0] wrAddr,
	input logic wrEn,
	input logic [31:0] wrData,
	output logic [31:0] rsData,
	output logic [31:0] rtData
);

	logic [31:0] regs [1:`REG_COUNT-1]; // no storage for r0

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 1; i < `REG_COUNT; i++)
				regs[i] <= '0;
		end else if (wrEn && wrAddr != 5'd0) begin
			regs[wrAddr] <= wrData;
		end
	end

	// write-through covers the distance-3 dependence
	assign rsData = (rsAddr == 5'd0) ? 32'd0 :
		(wrEn && wrAddr == rsAddr) ? wrData : regs[rsAddr];
	assign rtData = (rtAddr == 5'd0) ? 32'd0 :
		(wrEn && wrAddr == rtAddr) ? wrData : regs[rtAddr];

	// decode clears regWe for r0, so WB never targets it
	aWrNotZero: assert property (@(posedge clk) disable iff (rst) wrEn |-> wrAddr != 5'd0);

endmodule

// ==== src/pipePkg.sv ====
// ######################################
// control encodings carried between stages
// ######################################
package pipePkg;

	// ALU function picked in decode
	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_SLT // signed compare
	} aluOp_t;

	// source of the register writeback value
	typedef enum logic {
		WB_ALU,
		WB_MEM
	} wbSrc_t;

endpackage

// ==== src/isaPkg.sv ====
// ######################################
// MIPS32 instruction formats and encodings
// only the subset the pipeline executes
// ######################################
package isaPkg;

	typedef struct packed {
		logic [5:0] opcode;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} rFormat_t;

	typedef struct packed {
		logic [5:0] opcode;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [15:0] imm16;
	} iFormat_t;

	// same 32-bit word, two decodings
	typedef union packed {
		rFormat_t rFormat;
		iFormat_t iFormat;
	} instWord_t;

	localparam logic [5:0] OP_RTYPE = 6'h00;
	localparam logic [5:0] OP_ADDI = 6'h08;
	localparam logic [5:0] OP_ANDI = 6'h0c;
	localparam logic [5:0] OP_ORI = 6'h0d;
	localparam logic [5:0] OP_LW = 6'h23;
	localparam logic [5:0] OP_SW = 6'h2b;

	localparam logic [5:0] FN_ADD = 6'h20;
	localparam logic [5:0] FN_SUB = 6'h22;
	localparam logic [5:0] FN_AND = 6'h24;
	localparam logic [5:0] FN_OR = 6'h25;
	localparam logic [5:0] FN_SLT = 6'h2a;

endpackage

// ==== src/mips32_params.svh ====
// ######################################
// sizes shared by register file and data memory
// data memory is word addressed by bits 7:2
// ######################################
`ifndef MIPS32_PARAMS_SVH
`define MIPS32_PARAMS_SVH

`define REG_COUNT 32

// data memory depth in words
`define DATA_MEM_WORDS 64
`define DATA_MEM_ADDR_SIZE 6

`endif
